// File: dv/floo_lite_asserts.sv
// Link handshake checks for the floo_lite chimney
// Bound onto the top level from the testbench

`timescale 1ns/1ns

module floo_lite_asserts
  import floo_lite_flit_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input req_flit_t floo_req_o,
  input logic      floo_req_valid_o,
  input logic      floo_req_ready_i,
  input rsp_flit_t floo_rsp_i,
  input logic      floo_rsp_ready_o
);

  logic req_xfer;
  logic in_pkt_q;
  int   err_cnt = 0;

  assign req_xfer = floo_req_valid_o && floo_req_ready_i;

  // High between a non-last flit and the last flit of its packet
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_pkt_q <= 1'b0;
    end else if (req_xfer) begin
      in_pkt_q <= !floo_req_o.hdr.last;
    end
  end

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    floo_req_valid_o && !floo_req_ready_i |=> floo_req_valid_o && $stable(floo_req_o))
    else begin
      $error("Request flit changed or dropped before it was accepted");
      err_cnt++;
    end

  w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_xfer && in_pkt_q |-> floo_req_o.hdr.axi_ch == CH_W)
    else begin
      $error("Flit inside a write packet is not a W flit");
      err_cnt++;
    end

  rsp_tag_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(floo_rsp_i.hdr.axi_ch inside {CH_B, CH_R}) |-> !floo_rsp_ready_o)
    else begin
      $error("Response link accepted a flit that is neither B nor R");
      err_cnt++;
    end

endmodule

// File: dv/floo_lite_tb.sv
// Testbench for the floo_lite chimney
// Runs a table of AXI4-Lite writes and reads, models the network with random
// back-pressure and checks the request flits and the B/R responses

`timescale 1ns/1ns

`include "floo_lite_params.svh"

module floo_lite_tb
  import floo_lite_axi_pkg::*;
  import floo_lite_flit_pkg::*;
();

  typedef enum logic [1:0] {KIND_WR, KIND_RD, KIND_BOTH} kind_e;

  typedef struct packed {
    kind_e    kind;
    addr_t    addr;
    data_t    data;
    node_id_t dst;
  } entry_t;

  localparam int       NUM_ENTRIES = 9;
  localparam int       TIMEOUT     = 200;
  localparam node_id_t NODE_ID     = 4'd7;
  localparam data_t    RDATA_KEY   = 32'hA5A5_5A5A;

  // Kind, address, write data seed, expected destination
  localparam entry_t STIM [NUM_ENTRIES] = '{
    '{KIND_WR,   `FLOO_RULE0_BASE + 32'h10,   32'h1111_2222, `FLOO_RULE0_ID},
    '{KIND_RD,   `FLOO_RULE0_BASE + 32'h10,   32'h0000_0000, `FLOO_RULE0_ID},
    '{KIND_WR,   `FLOO_RULE1_END - 32'h4,     32'h3333_4444, `FLOO_RULE1_ID},
    '{KIND_RD,   `FLOO_RULE2_BASE,            32'h0000_0000, `FLOO_RULE2_ID},
    '{KIND_WR,   32'h4000_0000,               32'h7777_8888, `FLOO_DEFAULT_ID},
    '{KIND_RD,   `FLOO_RULE2_END,             32'h0000_0000, `FLOO_DEFAULT_ID},
    '{KIND_BOTH, `FLOO_RULE1_BASE,            32'h9999_aaaa, `FLOO_RULE1_ID},
    '{KIND_BOTH, `FLOO_RULE2_BASE + 32'h100,  32'h5555_6666, `FLOO_RULE2_ID},
    '{KIND_BOTH, `FLOO_RULE0_END - 32'h4,     32'hbbbb_cccc, `FLOO_RULE0_ID}
  };

  logic      clk;
  logic      rst_n;
  addr_t     awaddr;
  prot_t     awprot;
  logic      awvalid, awready;
  data_t     wdata;
  strb_t     wstrb;
  logic      wvalid, wready;
  resp_t     bresp;
  logic      bvalid, bready;
  addr_t     araddr;
  prot_t     arprot;
  logic      arvalid, arready;
  data_t     rdata;
  resp_t     rresp;
  logic      rvalid, rready;
  req_flit_t floo_req;
  logic      floo_req_valid, floo_req_ready;
  rsp_flit_t floo_rsp;
  logic      floo_rsp_valid, floo_rsp_ready;

  logic [15:0] lfsr;
  string       test_name;
  req_flit_t   req_log [$];
  rsp_flit_t   rsp_q [$];
  resp_t       b_log [$];
  logic [33:0] r_log [$];
  logic        aw_pend, w_pend, ar_pend;
  addr_t       cur_addr;
  prot_t       cur_prot;
  data_t       cur_data;
  strb_t       cur_strb;

  floo_lite_chimney dut_i (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .node_id_i        ( NODE_ID        ),
    .awaddr_i         ( awaddr         ),
    .awprot_i         ( awprot         ),
    .awvalid_i        ( awvalid        ),
    .awready_o        ( awready        ),
    .wdata_i          ( wdata          ),
    .wstrb_i          ( wstrb          ),
    .wvalid_i         ( wvalid         ),
    .wready_o         ( wready         ),
    .bresp_o          ( bresp          ),
    .bvalid_o         ( bvalid         ),
    .bready_i         ( bready         ),
    .araddr_i         ( araddr         ),
    .arprot_i         ( arprot         ),
    .arvalid_i        ( arvalid        ),
    .arready_o        ( arready        ),
    .rdata_o          ( rdata          ),
    .rresp_o          ( rresp          ),
    .rvalid_o         ( rvalid         ),
    .rready_i         ( rready         ),
    .floo_req_o       ( floo_req       ),
    .floo_req_valid_o ( floo_req_valid ),
    .floo_req_ready_i ( floo_req_ready ),
    .floo_rsp_i       ( floo_rsp       ),
    .floo_rsp_valid_i ( floo_rsp_valid ),
    .floo_rsp_ready_o ( floo_rsp_ready )
  );

  bind floo_lite_chimney floo_lite_asserts i_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Network answers unmapped destinations with an error
  function automatic resp_t resp_for(input node_id_t dst);
    return (dst == `FLOO_DEFAULT_ID) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  task automatic compare(input string field, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, field, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  endtask

  // Network model returns one B per W flit and one R per AR flit in order
  task automatic answer_request(input req_flit_t f);
    rsp_flit_t r;
    r            = '0;
    r.hdr.dst_id = f.hdr.src_id;
    r.hdr.src_id = f.hdr.dst_id;
    r.hdr.last   = 1'b1;
    if (f.hdr.axi_ch == CH_W) begin
      r.hdr.axi_ch     = CH_B;
      r.payload.b.resp = resp_for(f.hdr.dst_id);
      rsp_q.push_back(r);
    end else if (f.hdr.axi_ch == CH_AR) begin
      r.hdr.axi_ch     = CH_R;
      r.payload.r.data = f.payload.ax.addr ^ RDATA_KEY;
      r.payload.r.resp = resp_for(f.hdr.dst_id);
      rsp_q.push_back(r);
    end
  endtask

  // Drive on the falling edge, record handshakes on the rising edge
  task automatic run_cycle();
    logic is_b;
    logic is_r;
    logic req_xfer;
    @(negedge clk);
    compare("assertion errors", 0, dut_i.i_asserts.err_cnt);
    awaddr         = cur_addr;
    awprot         = cur_prot;
    awvalid        = aw_pend;
    wdata          = cur_data;
    wstrb          = cur_strb;
    wvalid         = w_pend;
    araddr         = cur_addr;
    arprot         = cur_prot;
    arvalid        = ar_pend;
    floo_req_ready = lfsr_bit() | lfsr_bit();
    bready         = lfsr_bit();
    rready         = lfsr_bit();
    floo_rsp_valid = (rsp_q.size() != 0);
    if (rsp_q.size() != 0) begin
      floo_rsp = rsp_q[0];
    end else begin
      floo_rsp = '0;
    end
    @(posedge clk);
    req_xfer = floo_req_valid && floo_req_ready;
    // Each AXI ready marks the link transfer of its own flit
    compare("awready", req_xfer && (floo_req.hdr.axi_ch == CH_AW), awready);
    compare("wready", req_xfer && (floo_req.hdr.axi_ch == CH_W), wready);
    compare("arready", req_xfer && (floo_req.hdr.axi_ch == CH_AR), arready);
    if (req_xfer) begin
      req_log.push_back(floo_req);
      answer_request(floo_req);
    end
    is_b = floo_rsp_valid && (floo_rsp.hdr.axi_ch == CH_B);
    is_r = floo_rsp_valid && (floo_rsp.hdr.axi_ch == CH_R);
    compare("bvalid", is_b, bvalid);
    compare("rvalid", is_r, rvalid);
    if (floo_rsp_valid) begin
      // Held response must not be taken while its channel stalls
      compare("rsp ready", is_b ? bready : rready, floo_rsp_ready);
      if (floo_rsp_ready) begin
        void'(rsp_q.pop_front());
      end
    end
    if (bvalid && bready) begin
      b_log.push_back(bresp);
    end
    if (rvalid && rready) begin
      r_log.push_back({rdata, rresp});
    end
    if (awvalid && awready) begin
      aw_pend = 1'b0;
    end
    if (wvalid && wready) begin
      w_pend = 1'b0;
    end
    if (arvalid && arready) begin
      ar_pend = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Flit and response checks for one table entry

  task automatic check_entry(input entry_t e);
    req_flit_t f;
    int        n_aw;
    int        n_ar;
    int        i;
    n_aw = 0;
    n_ar = 0;
    i    = 0;
    while (i < req_log.size()) begin
      f = req_log[i];
      compare("dst id", e.dst, f.hdr.dst_id);
      compare("src id", NODE_ID, f.hdr.src_id);
      compare("addr", cur_addr, f.payload.ax.addr);
      compare("prot", cur_prot, f.payload.ax.prot);
      if (f.hdr.axi_ch == CH_AW) begin
        compare("aw last", 1'b0, f.hdr.last);
        // The W flit must follow its AW directly
        compare("w follows aw", 1'b1, (i + 1) < req_log.size());
        f = req_log[i + 1];
        compare("w channel", CH_W, f.hdr.axi_ch);
        compare("w dst id", e.dst, f.hdr.dst_id);
        compare("w src id", NODE_ID, f.hdr.src_id);
        compare("w last", 1'b1, f.hdr.last);
        compare("w data", cur_data, f.payload.w.data);
        compare("w strb", cur_strb, f.payload.w.strb);
        n_aw++;
        i += 2;
      end else begin
        compare("ar channel", CH_AR, f.hdr.axi_ch);
        compare("ar last", 1'b1, f.hdr.last);
        n_ar++;
        i++;
      end
    end
    compare("aw count", e.kind != KIND_RD, n_aw);
    compare("ar count", e.kind != KIND_WR, n_ar);
    if (n_aw != 0) begin
      compare("bresp", resp_for(e.dst), b_log[0]);
    end
    if (n_ar != 0) begin
      compare("rdata rresp", {e.addr ^ RDATA_KEY, resp_for(e.dst)}, r_log[0]);
    end
    req_log.delete();
    b_log.delete();
    r_log.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    entry_t e;
    int     cnt;
    int     n_b;
    int     n_r;
    lfsr           = 16'd37672;
    test_name      = "reset";
    rst_n          = 1'b0;
    cur_addr       = '0;
    cur_prot       = '0;
    cur_data       = '0;
    cur_strb       = '0;
    aw_pend        = 1'b0;
    w_pend         = 1'b0;
    ar_pend        = 1'b0;
    awaddr         = '0;
    awprot         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arprot         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    floo_req_ready = 1'b0;
    floo_rsp       = '0;
    floo_rsp_valid = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int n = 0; n < NUM_ENTRIES; n++) begin
      e         = STIM[n];
      test_name = $sformatf("entry %0d", n);
      cur_addr  = e.addr;
      cur_prot  = prot_t'(lfsr_word(3));
      cur_data  = e.data ^ lfsr_word(32);
      cur_strb  = strb_t'(lfsr_word(4));
      aw_pend   = (e.kind != KIND_RD);
      w_pend    = (e.kind != KIND_RD);
      ar_pend   = (e.kind != KIND_WR);
      n_b       = (e.kind != KIND_RD) ? 1 : 0;
      n_r       = (e.kind != KIND_WR) ? 1 : 0;
      cnt       = 0;
      while (aw_pend || w_pend || ar_pend) begin
        run_cycle();
        cnt++;
        if (cnt > TIMEOUT) begin
          give_up("the AXI request handshakes");
        end
      end
      cnt = 0;
      while ((b_log.size() < n_b) || (r_log.size() < n_r)) begin
        run_cycle();
        cnt++;
        if (cnt > TIMEOUT) begin
          give_up("the B or R response");
        end
      end
      check_entry(e);
    end

    test_name = "end of run";
    @(negedge clk);
    compare("assertion errors", 0, dut_i.i_asserts.err_cnt);
    compare("pending responses", 0, rsp_q.size());
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: floo_lite.f
+incdir+source
source/floo_lite_axi_pkg.sv
source/floo_lite_flit_pkg.sv
source/floo_lite_route_comp.sv
source/floo_lite_write_packer.sv
source/floo_lite_read_packer.sv
source/floo_lite_wormhole_arbiter.sv
source/floo_lite_unpacker.sv
source/floo_lite_chimney.sv
dv/floo_lite_asserts.sv
dv/floo_lite_tb.sv

// File: source/floo_lite_axi_pkg.sv
// AXI4-Lite field types and response codes
// Imported by every block that touches the manager-side channels

`include "floo_lite_params.svh"

package floo_lite_axi_pkg;

  typedef logic [`FLOO_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`FLOO_DATA_WIDTH-1:0]   data_t;
  typedef logic [`FLOO_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [2:0]                    prot_t;
  typedef logic [1:0]                    resp_t;

  // Response codes, EXOKAY unused on AXI4-Lite
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

endpackage

// File: source/floo_lite_chimney.sv
// AXI4-Lite manager-side network interface
// Packs AW/W and AR into request flits and unpacks B and R responses

`timescale 1ns/1ns

module floo_lite_chimney
  import floo_lite_axi_pkg::*;
  import floo_lite_flit_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  node_id_t  node_id_i,
  // AXI4-Lite subordinate port
  input  addr_t     awaddr_i,
  input  prot_t     awprot_i,
  input  logic      awvalid_i,
  output logic      awready_o,
  input  data_t     wdata_i,
  input  strb_t     wstrb_i,
  input  logic      wvalid_i,
  output logic      wready_o,
  output resp_t     bresp_o,
  output logic      bvalid_o,
  input  logic      bready_i,
  input  addr_t     araddr_i,
  input  prot_t     arprot_i,
  input  logic      arvalid_i,
  output logic      arready_o,
  output data_t     rdata_o,
  output resp_t     rresp_o,
  output logic      rvalid_o,
  input  logic      rready_i,
  // Network links
  output req_flit_t floo_req_o,
  output logic      floo_req_valid_o,
  input  logic      floo_req_ready_i,
  input  rsp_flit_t floo_rsp_i,
  input  logic      floo_rsp_valid_i,
  output logic      floo_rsp_ready_o
);

  req_flit_t wr_flit;
  req_flit_t rd_flit;
  logic      wr_valid;
  logic      wr_last;
  logic      wr_grant;
  logic      rd_valid;
  logic      rd_grant;

  //////////////////////////////////////////////////////////////////////
  // Request path

  floo_lite_write_packer i_write_packer (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .node_id_i ( node_id_i ),
    .awaddr_i  ( awaddr_i  ),
    .awprot_i  ( awprot_i  ),
    .awvalid_i ( awvalid_i ),
    .awready_o ( awready_o ),
    .wdata_i   ( wdata_i   ),
    .wstrb_i   ( wstrb_i   ),
    .wvalid_i  ( wvalid_i  ),
    .wready_o  ( wready_o  ),
    .flit_o    ( wr_flit   ),
    .valid_o   ( wr_valid  ),
    .last_o    ( wr_last   ),
    .grant_i   ( wr_grant  )
  );

  floo_lite_read_packer i_read_packer (
    .node_id_i ( node_id_i ),
    .araddr_i  ( araddr_i  ),
    .arprot_i  ( arprot_i  ),
    .arvalid_i ( arvalid_i ),
    .arready_o ( arready_o ),
    .flit_o    ( rd_flit   ),
    .valid_o   ( rd_valid  ),
    .grant_i   ( rd_grant  )
  );

  // Write is input 0, read is input 1
  floo_lite_wormhole_arbiter i_req_arbiter (
    .clk_i      ( clk_i            ),
    .rst_n_i    ( rst_n_i          ),
    .wr_flit_i  ( wr_flit          ),
    .wr_valid_i ( wr_valid         ),
    .wr_last_i  ( wr_last          ),
    .wr_grant_o ( wr_grant         ),
    .rd_flit_i  ( rd_flit          ),
    .rd_valid_i ( rd_valid         ),
    .rd_grant_o ( rd_grant         ),
    .flit_o     ( floo_req_o       ),
    .valid_o    ( floo_req_valid_o ),
    .ready_i    ( floo_req_ready_i )
  );

  //////////////////////////////////////////////////////////////////////
  // Response path

  floo_lite_unpacker i_unpacker (
    .flit_i   ( floo_rsp_i       ),
    .valid_i  ( floo_rsp_valid_i ),
    .ready_o  ( floo_rsp_ready_o ),
    .bresp_o  ( bresp_o          ),
    .bvalid_o ( bvalid_o         ),
    .bready_i ( bready_i         ),
    .rdata_o  ( rdata_o          ),
    .rresp_o  ( rresp_o          ),
    .rvalid_o ( rvalid_o         ),
    .rready_i ( rready_i         )
  );

endmodule

// File: source/floo_lite_flit_pkg.sv
// Flit formats for the request and response links
// Header, channel tag and the payload unions that carry the AXI fields

`include "floo_lite_params.svh"

package floo_lite_flit_pkg;

  import floo_lite_axi_pkg::*;

  typedef logic [`FLOO_ID_WIDTH-1:0] node_id_t;

  typedef enum logic [2:0] {
    CH_AW = 3'd0,
    CH_W  = 3'd1,
    CH_AR = 3'd2,
    CH_B  = 3'd3,
    CH_R  = 3'd4
  } axi_ch_e;

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } hdr_t;

  ////////////////////////////////////////////////////////////////////
  // Request payload, AW/AR and W share one word

  localparam int unsigned AX_PAD_WIDTH =
    $bits(data_t) + $bits(strb_t) - $bits(addr_t) - $bits(prot_t);

  typedef struct packed {
    logic [AX_PAD_WIDTH-1:0] rsvd;
    addr_t                   addr;
    prot_t                   prot;
  } ax_payload_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_payload_t;

  typedef union packed {
    ax_payload_t ax;
    w_payload_t  w;
  } req_payload_u;

  ////////////////////////////////////////////////////////////////////
  // Response payload, B only uses the low bits

  typedef struct packed {
    data_t rsvd;
    resp_t resp;
  } b_payload_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_payload_t;

  typedef union packed {
    b_payload_t b;
    r_payload_t r;
  } rsp_payload_u;

  typedef struct packed {
    hdr_t         hdr;
    req_payload_u payload;
  } req_flit_t;

  typedef struct packed {
    hdr_t         hdr;
    rsp_payload_u payload;
  } rsp_flit_t;

endpackage

// File: source/floo_lite_params.svh
// Width and address map settings shared by the floo_lite network interface
// Include wherever a width or a map rule is needed

`ifndef FLOO_LITE_PARAMS_SVH
`define FLOO_LITE_PARAMS_SVH

`define FLOO_ADDR_WIDTH 32
`define FLOO_DATA_WIDTH 32
`define FLOO_ID_WIDTH   4

// Address map, each rule covers [base, end)
`define FLOO_NUM_RULES  3
`define FLOO_RULE0_BASE 32'h0000_0000
`define FLOO_RULE0_END  32'h0001_0000
`define FLOO_RULE0_ID   4'd1
`define FLOO_RULE1_BASE 32'h0001_0000
`define FLOO_RULE1_END  32'h0002_0000
`define FLOO_RULE1_ID   4'd2
`define FLOO_RULE2_BASE 32'h8000_0000
`define FLOO_RULE2_END  32'h9000_0000
`define FLOO_RULE2_ID   4'd3
`define FLOO_DEFAULT_ID 4'd0

`endif

// File: source/floo_lite_read_packer.sv
// Read request packer
// Turns one AR beat into a single last flit for the request link

`timescale 1ns/1ns

module floo_lite_read_packer
  import floo_lite_axi_pkg::*;
  import floo_lite_flit_pkg::*;
(
  input  node_id_t  node_id_i,
  input  addr_t     araddr_i,
  input  prot_t     arprot_i,
  input  logic      arvalid_i,
  output logic      arready_o,
  output req_flit_t flit_o,
  output logic      valid_o,
  input  logic      grant_i
);

  node_id_t ar_dst;

  floo_lite_route_comp i_route_comp (
    .addr_i   ( araddr_i ),
    .dst_id_o ( ar_dst   )
  );

  assign valid_o   = arvalid_i;
  assign arready_o = grant_i;

  always_comb begin
    flit_o                 = '0;
    flit_o.hdr.dst_id      = ar_dst;
    flit_o.hdr.src_id      = node_id_i;
    flit_o.hdr.axi_ch      = CH_AR;
    flit_o.hdr.last        = 1'b1;
    flit_o.payload.ax.addr = araddr_i;
    flit_o.payload.ax.prot = arprot_i;
  end

endmodule

// File: source/floo_lite_route_comp.sv
// Address decoder for outgoing requests
// Maps an AXI address to the destination node of the first matching rule,
// unmapped addresses go to the default node

`timescale 1ns/1ns

`include "floo_lite_params.svh"

module floo_lite_route_comp
  import floo_lite_axi_pkg::*;
  import floo_lite_flit_pkg::*;
(
  input  addr_t    addr_i,
  output node_id_t dst_id_o
);

  localparam addr_t RULE_BASE [`FLOO_NUM_RULES] = '{
    `FLOO_RULE0_BASE, `FLOO_RULE1_BASE, `FLOO_RULE2_BASE
  };
  localparam addr_t RULE_END [`FLOO_NUM_RULES] = '{
    `FLOO_RULE0_END, `FLOO_RULE1_END, `FLOO_RULE2_END
  };
  localparam node_id_t RULE_ID [`FLOO_NUM_RULES] = '{
    `FLOO_RULE0_ID, `FLOO_RULE1_ID, `FLOO_RULE2_ID
  };

  // Walk from the last rule down so the lowest index wins on overlap
  always_comb begin
    dst_id_o = `FLOO_DEFAULT_ID;
    for (int i = `FLOO_NUM_RULES - 1; i >= 0; i--) begin
      if ((addr_i >= RULE_BASE[i]) && (addr_i < RULE_END[i])) begin
        dst_id_o = RULE_ID[i];
      end
    end
  end

endmodule

// File: source/floo_lite_unpacker.sv
// Response unpacker
// Steers an incoming response flit to B or R by its channel tag

`timescale 1ns/1ns

module floo_lite_unpacker
  import floo_lite_axi_pkg::*;
  import floo_lite_flit_pkg::*;
(
  input  rsp_flit_t flit_i,
  input  logic      valid_i,
  output logic      ready_o,
  output resp_t     bresp_o,
  output logic      bvalid_o,
  input  logic      bready_i,
  output data_t     rdata_o,
  output resp_t     rresp_o,
  output logic      rvalid_o,
  input  logic      rready_i
);

  logic is_b;
  logic is_r;

  assign is_b = (flit_i.hdr.axi_ch == CH_B);
  assign is_r = (flit_i.hdr.axi_ch == CH_R);

  assign bvalid_o = valid_i && is_b;
  assign rvalid_o = valid_i && is_r;
  assign bresp_o  = flit_i.payload.b.resp;
  assign rdata_o  = flit_i.payload.r.data;
  assign rresp_o  = flit_i.payload.r.resp;

  // Request-side tags never get accepted here
  assign ready_o  = (is_b && bready_i) || (is_r && rready_i);

endmodule

// File: source/floo_lite_wormhole_arbiter.sv
// Two-input round-robin arbiter for the request link
// Once a non-last write flit leaves, the link stays with the write input
// until its last flit has gone

`timescale 1ns/1ns

module floo_lite_wormhole_arbiter
  import floo_lite_flit_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  req_flit_t wr_flit_i,
  input  logic      wr_valid_i,
  input  logic      wr_last_i,
  output logic      wr_grant_o,
  input  req_flit_t rd_flit_i,
  input  logic      rd_valid_i,
  output logic      rd_grant_o,
  output req_flit_t flit_o,
  output logic      valid_o,
  input  logic      ready_i
);

  logic lock_q;
  logic stall_q;
  logic sel_q;
  logic prio_q;
  logic sel_rd;
  logic sel_last;
  logic xfer;

  // Lock beats a stalled choice, a stalled choice beats round robin
  always_comb begin
    if (lock_q) begin
      sel_rd = 1'b0;
    end else if (stall_q) begin
      sel_rd = sel_q;
    end else if (wr_valid_i && rd_valid_i) begin
      sel_rd = prio_q;
    end else begin
      sel_rd = rd_valid_i;
    end
  end

  assign flit_o     = sel_rd ? rd_flit_i : wr_flit_i;
  assign valid_o    = sel_rd ? rd_valid_i : wr_valid_i;
  assign sel_last   = sel_rd ? rd_flit_i.hdr.last : wr_last_i;
  assign xfer       = valid_o && ready_i;
  assign wr_grant_o = xfer && !sel_rd;
  assign rd_grant_o = xfer && sel_rd;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;
      stall_q <= 1'b0;
      sel_q   <= 1'b0;
      prio_q  <= 1'b0;
    end else begin
      stall_q <= valid_o && !ready_i;
      sel_q   <= sel_rd;
      if (xfer) begin
        lock_q <= !sel_last;
        // Hand priority over only when a whole packet is out
        if (sel_last) begin
          prio_q <= !sel_rd;
        end
      end
    end
  end

endmodule

// File: source/floo_lite_write_packer.sv
// Write request packer
// Sends the AW beat as a non-last flit, then the W beat as the last flit
// to the same destination

`timescale 1ns/1ns

module floo_lite_write_packer
  import floo_lite_axi_pkg::*;
  import floo_lite_flit_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  node_id_t  node_id_i,
  input  addr_t     awaddr_i,
  input  prot_t     awprot_i,
  input  logic      awvalid_i,
  output logic      awready_o,
  input  data_t     wdata_i,
  input  strb_t     wstrb_i,
  input  logic      wvalid_i,
  output logic      wready_o,
  output req_flit_t flit_o,
  output logic      valid_o,
  output logic      last_o,
  input  logic      grant_i
);

  typedef enum logic {PHASE_AW, PHASE_W} phase_e;

  phase_e   phase_q;
  node_id_t aw_dst;
  node_id_t dst_q;

  floo_lite_route_comp i_route_comp (
    .addr_i   ( awaddr_i ),
    .dst_id_o ( aw_dst   )
  );

  assign valid_o   = (phase_q == PHASE_AW) ? awvalid_i : wvalid_i;
  assign last_o    = (phase_q == PHASE_W);
  assign awready_o = grant_i && (phase_q == PHASE_AW);
  assign wready_o  = grant_i && (phase_q == PHASE_W);

  always_comb begin
    flit_o            = '0;
    flit_o.hdr.src_id = node_id_i;
    flit_o.hdr.last   = last_o;
    if (phase_q == PHASE_AW) begin
      flit_o.hdr.dst_id      = aw_dst;
      flit_o.hdr.axi_ch      = CH_AW;
      flit_o.payload.ax.addr = awaddr_i;
      flit_o.payload.ax.prot = awprot_i;
    end else begin
      // W follows the AW to wherever it went
      flit_o.hdr.dst_id      = dst_q;
      flit_o.hdr.axi_ch      = CH_W;
      flit_o.payload.w.data  = wdata_i;
      flit_o.payload.w.strb  = wstrb_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= PHASE_AW;
    end else if (awready_o) begin
      phase_q <= PHASE_W;
    end else if (wready_o) begin
      phase_q <= PHASE_AW;
    end
  end

  always_ff @(posedge clk_i) begin
    if (awready_o) begin
      dst_q <= aw_dst;
    end
  end

endmodule
